//--- flist.f
+incdir+source
+incdir+bench
source/adc_rx_pkg.sv
source/adc_dfmt.sv
source/adc_rx_regs.sv
source/adc_rx_core.sv
bench/tb_clkgen.sv
bench/adc_rx_tb.sv

//--- Makefile
# Verilator build and run for the adc receive path testbench
# a failing run exits non-zero through $fatal

VERILATOR ?= verilator
TOP       ?= adc_rx_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/adc_rx_checks.svh
// adc receive testbench checks
// compare tasks for samples, valid and read data, and the host port sequences

`ifndef ADC_RX_CHECKS_SVH
`define ADC_RX_CHECKS_SVH

task automatic check_smp(input adc_rx_pkg::adc_smp_t got, input adc_rx_pkg::adc_smp_t want);
  if (got !== want) begin
    abort_run($sformatf("FAIL smp_out got %h expected %h", got, want));
  end
endtask

task automatic check_valid(input logic got, input logic want);
  if (got !== want) begin
    abort_run($sformatf("FAIL smp_out.valid got %h expected %h", got, want));
  end
endtask

task automatic check_rdata(input string name, input logic [7:0] got, input logic [7:0] want);
  if (got !== want) begin
    abort_run($sformatf("FAIL cfg_rdata (%s) got %h expected %h", name, got, want));
  end
endtask

// one four-phase access
// req up, wait ack up, take rdata, req down, wait ack down
task automatic cfg_access(input adc_rx_pkg::cfg_cmd_t cmd, output logic [7:0] rdata);
  int n;
  @(negedge clk);
  cfg_cmd = cmd;
  cfg_req = 1'b1;
  n = 0;
  @(negedge clk);
  while (cfg_ack !== 1'b1) begin
    n++;
    if (n > CFG_TIMEOUT) begin
      abort_run("timeout waiting for cfg_ack to rise");
    end
    @(negedge clk);
  end
  // read data is held while ack is high
  rdata = cfg_rdata;
  cfg_req = 1'b0;
  n = 0;
  @(negedge clk);
  while (cfg_ack !== 1'b0) begin
    n++;
    if (n > CFG_TIMEOUT) begin
      abort_run("timeout waiting for cfg_ack to fall");
    end
    @(negedge clk);
  end
endtask

task automatic cfg_write(input logic [1:0] addr, input logic [7:0] data);
  adc_rx_pkg::cfg_cmd_t cmd;
  logic [7:0]           ignored;
  cmd.we    = 1'b1;
  cmd.addr  = addr;
  cmd.wdata = data;
  cfg_access(cmd, ignored);
endtask

task automatic cfg_read(input logic [1:0] addr, output logic [7:0] data);
  adc_rx_pkg::cfg_cmd_t cmd;
  cmd.we    = 1'b0;
  cmd.addr  = addr;
  cmd.wdata = '0;
  cfg_access(cmd, data);
endtask

`endif

//--- bench/adc_rx_tb.sv
// adc receive testbench
// random samples through both format stages against a model of the
// conversion rule, plus register access over the four-phase host port

`timescale 1ns/100ps
`default_nettype none

`include "adc_rx_params.svh"

module adc_rx_tb;

  localparam int CFG_TIMEOUT   = 50;
  localparam int RESET_TIMEOUT = 100;

  logic                 clk;
  logic                 rst_n;
  adc_rx_pkg::adc_raw_t smp_in;
  adc_rx_pkg::adc_smp_t smp_out;
  logic                 cfg_req;
  adc_rx_pkg::cfg_cmd_t cfg_cmd;
  logic                 cfg_ack;
  logic [7:0]           cfg_rdata;

  // model state with register copies and expected outputs
  integer                   seed;
  adc_rx_pkg::dfmt_ctrl_t   model_ctrl [`ADC_RX_NUM_CH];
  adc_rx_pkg::range_flags_t model_flags [`ADC_RX_NUM_CH];
  adc_rx_pkg::adc_smp_t     exp_q [$];

  tb_clkgen #(.PERIOD_NS(10), .RST_CYCLES(16)) u_clkgen (.clk(clk), .rst_n(rst_n));

  adc_rx_core uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .smp_in    (smp_in),
    .smp_out   (smp_out),
    .cfg_req   (cfg_req),
    .cfg_cmd   (cfg_cmd),
    .cfg_ack   (cfg_ack),
    .cfg_rdata (cfg_rdata)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  `include "adc_rx_checks.svh"

  // **************************************************
  // model
  // **************************************************

  // offset binary flips the msb and se copies it into the top nibble
  function automatic logic [`ADC_RX_OUT_W-1:0] convert(input logic [11:0] raw,
                                                      input adc_rx_pkg::dfmt_ctrl_t c);
    logic                     msb;
    logic [`ADC_RX_OUT_W-1:0] r;
    msb = raw[11];
    if (c.enable && c.fmt_type) begin
      msb = ~msb;
    end
    r = {4'h0, msb, raw[10:0]};
    if (c.enable && c.se && msb) begin
      r[15:12] = 4'hf;
    end
    return r;
  endfunction

  // top and bottom codes of the channel's coding
  function automatic adc_rx_pkg::range_flags_t range_of(input logic [11:0] raw,
                                                       input logic offset_bin);
    adc_rx_pkg::range_flags_t f;
    f.over  = offset_bin ? (raw == 12'hfff) : (raw == 12'h7ff);
    f.under = offset_bin ? (raw == 12'h000) : (raw == 12'h800);
    return f;
  endfunction

  function automatic logic [7:0] expected_reg(input logic [1:0] addr);
    case (addr)
      `ADC_RX_ADDR_CTRL0:  return {5'b0, model_ctrl[0]};
      `ADC_RX_ADDR_CTRL1:  return {5'b0, model_ctrl[1]};
      `ADC_RX_ADDR_STATUS: return {4'b0, model_flags[1], model_flags[0]};
      default:             return 8'h00;
    endcase
  endfunction

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  // about 1 in 8 codes lands on a range limit
  function automatic logic [11:0] rand_code();
    logic [31:0] r;
    r = next_rand();
    if (r[2:0] == 3'd0) begin
      case (r[4:3])
        2'd0:    return 12'hfff;
        2'd1:    return 12'h000;
        2'd2:    return 12'h7ff;
        default: return 12'h800;
      endcase
    end
    return r[19:8];
  endfunction

  // **************************************************
  // stimulus
  // **************************************************

  // check the previous cycle's output and drive the next input
  task automatic drive_and_check(input adc_rx_pkg::adc_raw_t in);
    adc_rx_pkg::adc_smp_t want;
    logic                 want_valid;
    @(negedge clk);
    want_valid = (exp_q.size() != 0);
    check_valid(smp_out.valid, want_valid);
    if (want_valid) begin
      check_smp(smp_out, exp_q.pop_front());
    end
    smp_in = in;
    if (in.valid) begin
      want.valid = 1'b1;
      for (int ch = 0; ch < `ADC_RX_NUM_CH; ch++) begin
        want.data[ch]   = convert(in.data[ch], model_ctrl[ch]);
        // flags follow the type bit even with enable clear
        model_flags[ch] = model_flags[ch] | range_of(in.data[ch], model_ctrl[ch].fmt_type);
      end
      exp_q.push_back(want);
    end
  endtask

  task automatic run_samples(input int count, input logic all_valid);
    adc_rx_pkg::adc_raw_t raw;
    logic [31:0]          r;
    for (int i = 0; i < count; i++) begin
      r = next_rand();
      raw.valid = all_valid | (r[1:0] != 2'b00);
      for (int ch = 0; ch < `ADC_RX_NUM_CH; ch++) begin
        raw.data[ch] = rand_code();
      end
      drive_and_check(raw);
    end
    // drain so status is settled before any access
    drive_and_check('0);
    drive_and_check('0);
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
    logic [3:0] stat;
    cfg_write(addr, data);
    case (addr)
      `ADC_RX_ADDR_CTRL0: model_ctrl[0] = data[2:0];
      `ADC_RX_ADDR_CTRL1: model_ctrl[1] = data[2:0];
      `ADC_RX_ADDR_STATUS: begin
        // write one to clear
        stat = {model_flags[1], model_flags[0]} & ~data[3:0];
        model_flags[1] = stat[3:2];
        model_flags[0] = stat[1:0];
      end
      default: ;
    endcase
  endtask

  task automatic read_check(input logic [1:0] addr, input string name);
    logic [7:0] rd;
    cfg_read(addr, rd);
    check_rdata(name, rd, expected_reg(addr));
  endtask

  task automatic read_all();
    read_check(`ADC_RX_ADDR_CTRL0, "ctrl0");
    read_check(`ADC_RX_ADDR_CTRL1, "ctrl1");
    read_check(`ADC_RX_ADDR_STATUS, "status");
    read_check(2'd3, "unused");
  endtask

  // each limit code of both codings alone on one channel with a status read after it
  task automatic probe_codes();
    adc_rx_pkg::adc_raw_t raw;
    logic [11:0]          codes [4];
    codes = '{12'hfff, 12'h000, 12'h7ff, 12'h800};
    for (int ch = 0; ch < `ADC_RX_NUM_CH; ch++) begin
      for (int k = 0; k < 4; k++) begin
        write_reg(`ADC_RX_ADDR_STATUS, 8'h0f);
        raw.valid = 1'b1;
        // 123 is no limit in either coding
        for (int c = 0; c < `ADC_RX_NUM_CH; c++) begin
          raw.data[c] = 12'h123;
        end
        raw.data[ch] = codes[k];
        drive_and_check(raw);
        drive_and_check('0);
        drive_and_check('0);
        read_check(`ADC_RX_ADDR_STATUS, "status");
      end
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst_n !== 1'b1) begin
      n++;
      if (n > RESET_TIMEOUT) begin
        abort_run("timeout waiting for reset release");
      end
      @(negedge clk);
    end
  endtask

  // **************************************************
  // test sequence
  // **************************************************

  initial begin
    adc_rx_pkg::adc_raw_t raw;
    logic [1:0]           mode;
    seed    = 32'h933b;
    smp_in  = '0;
    cfg_req = 1'b0;
    cfg_cmd = '0;
    for (int ch = 0; ch < `ADC_RX_NUM_CH; ch++) begin
      model_ctrl[ch]  = '0;
      model_flags[ch] = '0;
    end
    wait_reset_release();

    // idle after reset with all registers clear
    repeat (8) drive_and_check('0);
    read_all();

    // enable clear gives raw codes zero-extended
    run_samples(200, 1'b0);
    read_check(`ADC_RX_ADDR_STATUS, "status");

    // every type/se pair with ch1 on the swapped pair
    for (int m = 0; m < 4; m++) begin
      mode = m[1:0];
      write_reg(`ADC_RX_ADDR_CTRL0, {5'b0, 1'b1, mode[1], mode[0]});
      write_reg(`ADC_RX_ADDR_CTRL1, {5'b0, 1'b1, mode[0], mode[1]});
      probe_codes();
      run_samples(150, 1'b0);
      run_samples(40, 1'b1);
      read_all();
    end

    // clear only the over bits and then everything
    write_reg(`ADC_RX_ADDR_STATUS, 8'h05);
    read_check(`ADC_RX_ADDR_STATUS, "status");
    write_reg(`ADC_RX_ADDR_STATUS, 8'h0f);
    read_check(`ADC_RX_ADDR_STATUS, "status");

    // ch0 is offset binary now so fff sets its over bit again
    raw.valid   = 1'b1;
    raw.data[0] = 12'hfff;
    raw.data[1] = 12'h123;
    drive_and_check(raw);
    drive_and_check('0);
    drive_and_check('0);
    read_check(`ADC_RX_ADDR_STATUS, "status");

    // read-back with an unused address write that is dropped
    write_reg(`ADC_RX_ADDR_CTRL0, 8'hfa);
    write_reg(`ADC_RX_ADDR_CTRL1, 8'h05);
    write_reg(2'd3, 8'hff);
    read_all();

    // ch0 has type set with enable clear
    probe_codes();
    run_samples(100, 1'b0);
    read_all();

    if (exp_q.size() != 0) begin
      abort_run("expected samples left in the queue at end of run");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_clkgen.sv
// testbench clock and reset
// free running clock, synchronous reset held low for a fixed cycle count

`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- source/adc_rx_core.sv
// adc receive core
// one format stage per channel plus the register block that steers them

`timescale 1ns/100ps
`default_nettype none

`include "adc_rx_params.svh"

module adc_rx_core (
  input  wire logic                   clk,
  input  wire logic                   rst_n,

  // sample path
  input  wire adc_rx_pkg::adc_raw_t   smp_in,
  output adc_rx_pkg::adc_smp_t        smp_out,

  // host port
  input  wire logic                   cfg_req,
  input  wire adc_rx_pkg::cfg_cmd_t   cfg_cmd,
  output logic                        cfg_ack,
  output logic [7:0]                  cfg_rdata
);

  // per-channel wiring between stages and registers
  adc_rx_pkg::dfmt_ctrl_t   [`ADC_RX_NUM_CH-1:0]                    ch_ctrl;
  adc_rx_pkg::range_flags_t [`ADC_RX_NUM_CH-1:0]                    ch_flags;
  logic                     [`ADC_RX_NUM_CH-1:0]                    ch_valid;
  logic                     [`ADC_RX_NUM_CH-1:0][`ADC_RX_OUT_W-1:0] ch_data;

  // **************************************************
  // format stages
  // **************************************************

  // every channel sees the one shared input valid
  for (genvar ch = 0; ch < `ADC_RX_NUM_CH; ch++) begin : g_ch
    adc_dfmt #(
      .DATA_WIDTH (`ADC_RX_RAW_W)
    ) u_dfmt (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid     (smp_in.valid),
      .data      (smp_in.data[ch]),
      .ctrl      (ch_ctrl[ch]),
      .valid_out (ch_valid[ch]),
      .data_out  (ch_data[ch]),
      .flags     (ch_flags[ch])
    );
  end

  // channels stay in lockstep, so channel 0 speaks for all
  assign smp_out.valid = ch_valid[0];
  assign smp_out.data  = ch_data;

  // **************************************************
  // register block
  // **************************************************

  adc_rx_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_req     (cfg_req),
    .cfg_cmd     (cfg_cmd),
    .cfg_ack     (cfg_ack),
    .cfg_rdata   (cfg_rdata),
    .ctrl        (ch_ctrl),
    .flags_valid (ch_valid),
    .flags       (ch_flags)
  );

endmodule

`default_nettype wire

//--- source/adc_rx_regs.sv
// adc receive register block
// four-phase req/ack host port, per-channel format control registers
// and sticky over/under range status with write-one-to-clear

`timescale 1ns/100ps
`default_nettype none

`include "adc_rx_params.svh"

module adc_rx_regs (
  input  wire logic                                          clk,
  input  wire logic                                          rst_n,

  // host port
  input  wire logic                                          cfg_req,
  input  wire adc_rx_pkg::cfg_cmd_t                          cfg_cmd,
  output logic                                               cfg_ack,
  output logic [7:0]                                         cfg_rdata,

  // per-channel control to the format stages
  output adc_rx_pkg::dfmt_ctrl_t [`ADC_RX_NUM_CH-1:0]        ctrl,

  // per-channel range flags back from the format stages
  input  wire logic [`ADC_RX_NUM_CH-1:0]                     flags_valid,
  input  wire adc_rx_pkg::range_flags_t [`ADC_RX_NUM_CH-1:0] flags
);

  localparam int STAT_W = 2 * `ADC_RX_NUM_CH;

  // **************************************************
  // handshake FSM
  // **************************************************

  // idle: waiting for req
  // ack: access done, first cycle of ack
  // wait_rel: ack held until the host drops req
  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0,
    ST_ACK      = 2'd1,
    ST_WAIT_REL = 2'd2
  } cfg_state_t;

  cfg_state_t state_q;
  cfg_state_t state_d;
  logic       access;

  // exactly one access, on the first cycle req is seen in idle
  assign access = (state_q == ST_IDLE) & cfg_req;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cfg_req) begin
          state_d = ST_ACK;
        end
      end
      ST_ACK: begin
        // a fast host may already have released
        if (cfg_req) begin
          state_d = ST_WAIT_REL;
        end else begin
          state_d = ST_IDLE;
        end
      end
      ST_WAIT_REL: begin
        if (!cfg_req) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ack high in both non-idle states, drops the cycle after req low
  assign cfg_ack = (state_q != ST_IDLE);

  // **************************************************
  // control registers
  // **************************************************

  logic wr_ctrl0;
  logic wr_ctrl1;

  assign wr_ctrl0 = access & cfg_cmd.we & (cfg_cmd.addr == `ADC_RX_ADDR_CTRL0);
  assign wr_ctrl1 = access & cfg_cmd.we & (cfg_cmd.addr == `ADC_RX_ADDR_CTRL1);

  // new control applies to samples from the next clock on
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl <= '0;
    end else begin
      if (wr_ctrl0) begin
        ctrl[0] <= cfg_cmd.wdata[2:0];
      end
      if (wr_ctrl1) begin
        ctrl[1] <= cfg_cmd.wdata[2:0];
      end
    end
  end

  // **************************************************
  // sticky range status
  // **************************************************

  // bit layout {ch1 under, ch1 over, ch0 under, ch0 over}
  logic [STAT_W-1:0] status_q;
  logic [STAT_W-1:0] status_set;
  logic [STAT_W-1:0] status_clr;

  always_comb begin
    status_set = '0;
    for (int ch = 0; ch < `ADC_RX_NUM_CH; ch++) begin
      // flags only count with their sample
      if (flags_valid[ch]) begin
        status_set[2*ch +: 2] = flags[ch];
      end
    end
  end

  // write one to clear
  always_comb begin
    status_clr = '0;
    if (access && cfg_cmd.we && (cfg_cmd.addr == `ADC_RX_ADDR_STATUS)) begin
      status_clr = cfg_cmd.wdata[STAT_W-1:0];
    end
  end

  // a flag arriving with the clear wins
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~status_clr) | status_set;
    end
  end

  // **************************************************
  // read data
  // **************************************************

  logic [7:0] rdata_d;

  // unused addresses read zero
  always_comb begin
    rdata_d = '0;
    case (cfg_cmd.addr)
      `ADC_RX_ADDR_CTRL0:  rdata_d[2:0] = ctrl[0];
      `ADC_RX_ADDR_CTRL1:  rdata_d[2:0] = ctrl[1];
      `ADC_RX_ADDR_STATUS: rdata_d[STAT_W-1:0] = status_q;
      default:             rdata_d = '0;
    endcase
  end

  // captured with the access, valid while ack is high
  always_ff @(posedge clk) begin
    if (access) begin
      cfg_rdata <= rdata_d;
    end
  end

endmodule

`default_nettype wire

//--- source/adc_dfmt.sv
// adc data format stage
// offset binary to two's complement, sign or zero fill to 16 bits,
// and top/bottom code detection, all in one registered stage

`timescale 1ns/100ps
`default_nettype none

`include "adc_rx_params.svh"

module adc_dfmt #(
  parameter int DATA_WIDTH = `ADC_RX_RAW_W
) (
  input  wire logic                         clk,
  input  wire logic                         rst_n,

  // raw sample in
  input  wire logic                         valid,
  input  wire logic [DATA_WIDTH-1:0]        data,

  // format control from the register block
  input  wire adc_rx_pkg::dfmt_ctrl_t       ctrl,

  // formatted sample out
  output logic                              valid_out,
  output logic [`ADC_RX_OUT_W-1:0]          data_out,
  output adc_rx_pkg::range_flags_t          flags
);

  // **************************************************
  // conversion
  // **************************************************

  logic                      type_s;
  logic                      signext_s;
  logic                      msb_s;
  logic                      fill_s;
  logic [`ADC_RX_OUT_W-1:0]  data_s;

  // msb flips only for an enabled offset binary channel
  assign type_s    = ctrl.enable & ctrl.fmt_type;
  assign signext_s = ctrl.enable & ctrl.se;
  assign msb_s     = type_s ^ data[DATA_WIDTH-1];

  // upper bits copy the new msb, else zero
  assign fill_s = signext_s & msb_s;

  always_comb begin
    data_s = '0;
    data_s[DATA_WIDTH-2:0] = data[DATA_WIDTH-2:0];
    data_s[DATA_WIDTH-1] = msb_s;
    // fill everything above the raw width
    for (int i = DATA_WIDTH; i < `ADC_RX_OUT_W; i++) begin
      data_s[i] = fill_s;
    end
  end

  // **************************************************
  // range codes
  // **************************************************

  logic [DATA_WIDTH-1:0]     top_code;
  logic [DATA_WIDTH-1:0]     bot_code;
  adc_rx_pkg::range_flags_t  flags_s;

  // coding follows the type bit even with enable clear
  // offset binary: fff / 000, two's complement: 7ff / 800
  assign top_code = {ctrl.fmt_type, {(DATA_WIDTH-1){1'b1}}};
  assign bot_code = {~ctrl.fmt_type, {(DATA_WIDTH-1){1'b0}}};

  assign flags_s.over  = (data == top_code);
  assign flags_s.under = (data == bot_code);

  // **************************************************
  // output register
  // **************************************************

  // valid is control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid;
    end
  end

  // data and flags follow valid, held between samples
  always_ff @(posedge clk) begin
    if (valid) begin
      data_out <= data_s;
      flags    <= flags_s;
    end
  end

endmodule

`default_nettype wire

//--- source/adc_rx_pkg.sv
// adc receive path types
// sample buses, per-channel format control and host access command

`default_nettype none

`include "adc_rx_params.svh"

package adc_rx_pkg;

  // **************************************************
  // sample path
  // **************************************************

  // raw samples, one shared valid for all channels
  typedef struct packed {
    logic                                           valid;
    logic [`ADC_RX_NUM_CH-1:0][`ADC_RX_RAW_W-1:0]   data;
  } adc_raw_t;

  // formatted samples, 16 bits per channel
  typedef struct packed {
    logic                                           valid;
    logic [`ADC_RX_NUM_CH-1:0][`ADC_RX_OUT_W-1:0]   data;
  } adc_smp_t;

  // **************************************************
  // control and status
  // **************************************************

  // one channel's format control
  // fmt_type set means the converter delivers offset binary
  typedef struct packed {
    logic enable;
    logic fmt_type;
    logic se;
  } dfmt_ctrl_t;

  // range codes seen by one channel, under sits above over
  typedef struct packed {
    logic under;
    logic over;
  } range_flags_t;

  // **************************************************
  // host port
  // **************************************************

  // one register access, held stable while cfg_req is high
  typedef struct packed {
    logic       we;
    logic [1:0] addr;
    logic [7:0] wdata;
  } cfg_cmd_t;

endpackage

`default_nettype wire

//--- source/adc_rx_params.svh
// adc receive path parameters
// channel count, sample widths and register map of the host port

`ifndef ADC_RX_PARAMS_SVH
`define ADC_RX_PARAMS_SVH

// number of adc channels
`define ADC_RX_NUM_CH 2

// raw sample width from the converter
`define ADC_RX_RAW_W 12

// formatted sample width after extension
`define ADC_RX_OUT_W 16

// register map, 2-bit address space
`define ADC_RX_ADDR_CTRL0 2'd0
`define ADC_RX_ADDR_CTRL1 2'd1
`define ADC_RX_ADDR_STATUS 2'd2

`endif
